// File: compile.f
verilog/mcu_bridge_pkg.sv
verilog/mcu_cmd_decoder.sv
verilog/mcu_reg_file.sv
verilog/mem_transfer.sv
verilog/mcu_bridge_top.sv
testbench/tb_mem_model.sv
testbench/tb_mcu_bridge.sv

// File: Makefile
SOURCES = $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/Vtb_mcu_bridge
	@out=$$(./obj_dir/Vtb_mcu_bridge); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

obj_dir/Vtb_mcu_bridge: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_mcu_bridge -o Vtb_mcu_bridge

clean:
	rm -rf obj_dir

// File: testbench/tb_mcu_bridge.sv
`timescale 1ns/10ps

module tb_mcu_bridge;

    typedef struct packed {
        logic [7:0]       cmd;
        logic [7:0]       addr;
        logic [3:0]       n;       // Data bytes after the address
        logic [0:7][7:0]  data;
        logic [0:9][7:0]  exp;     // Reply after each byte sent
        logic [0:9][7:0]  mask;
        logic             poll;
    } frame_t;

    logic                         clk;
    logic                         reset;
    logic                         frame_start;
    logic                         data_ready;
    logic [7:0]                   rx_data;
    logic                         sd_det;
    logic                         button;
    mcu_bridge_pkg::mem_rsp_t     mem_rsp;
    mcu_bridge_pkg::fifo_status_t fifo_status;
    logic [7:0]                   tx_data;
    mcu_bridge_pkg::mem_req_t     mem_req;
    mcu_bridge_pkg::fifo_req_t    fifo_req;
    logic                         usb_reset_ack;
    logic                         write_buffer_flush;

    frame_t frames[$];
    logic   table_ready;
    int     errors;
    int     tx_writes;
    int     rx_reads;
    int     fifo_flushes;
    int     reset_acks;
    int     buffer_flushes;

    mcu_bridge_top #(.DEVICE_ID(8'h64), .SYNC_STAGES(3)) dut_i (
        .clk(clk), .reset(reset), .frame_start(frame_start), .data_ready(data_ready),
        .rx_data(rx_data), .sd_det(sd_det), .button(button), .mem_rsp(mem_rsp),
        .fifo_status(fifo_status), .tx_data(tx_data), .mem_req(mem_req),
        .fifo_req(fifo_req), .usb_reset_ack(usb_reset_ack),
        .write_buffer_flush(write_buffer_flush)
    );

    tb_mem_model mem_i (.clk(clk), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic add_frame(input logic [7:0] cmd, input logic [7:0] addr, input int n,
                             input logic [63:0] data, input logic [79:0] exp,
                             input logic [79:0] mask, input logic poll);
        frame_t f;
        f.cmd  = cmd;
        f.addr = addr;
        f.n    = 4'(n);
        f.data = data;
        f.exp  = exp;
        f.mask = mask;
        f.poll = poll;
        frames.push_back(f);
    endtask

    // One byte, then the reply just before the next byte may go out
    task automatic send_byte(input logic [7:0] b, output logic [7:0] reply);
        @(posedge clk);
        rx_data    <= b;
        data_ready <= 1'b1;
        @(posedge clk);
        data_ready <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reply = tx_data;
    endtask

    task automatic run_frame(input frame_t f, output logic [0:9][7:0] reply);
        logic [7:0] r;
        reply = '0;
        @(posedge clk);
        frame_start <= 1'b1;
        @(posedge clk);
        frame_start <= 1'b0;
        send_byte(f.cmd, r);
        reply[0] = r;
        send_byte(f.addr, r);
        reply[1] = r;
        for (int k = 0; k < int'(f.n); k++) begin
            send_byte(f.data[k], r);
            reply[k + 2] = r;
        end
    endtask

    // FIFO and USB pulses
    always @(posedge clk) begin
        if (!reset) begin
            if (fifo_req.tx_write) begin
                tx_writes++;
                check("tx_wdata", 32'(fifo_req.tx_wdata), 32'h0000_00C3);
            end
            if (fifo_req.rx_read) rx_reads++;
            if (fifo_req.fifo_flush) fifo_flushes++;
            if (usb_reset_ack) reset_acks++;
            if (write_buffer_flush) buffer_flushes++;
        end
    end

    // ==============================
    // Watchdog
    // ==============================

    initial begin
        wait (table_ready === 1'b1);
        repeat (frames.size() * 60 + 2000) @(posedge clk);
        $display("Timeout: the test sequence did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        logic [0:9][7:0] reply;
        logic [15:0]     burst_words [0:3];
        bit              done;

        errors         = 0;
        tx_writes      = 0;
        rx_reads       = 0;
        fifo_flushes   = 0;
        reset_acks     = 0;
        buffer_flushes = 0;
        table_ready    = 1'b0;
        reset          = 1'b1;
        frame_start    = 1'b0;
        data_ready     = 1'b0;
        rx_data        = 8'h00;
        sd_det         = 1'b1;
        button         = 1'b0;
        fifo_status    = '{rx_empty: 1'b0, tx_full: 1'b1, rx_rdata: 8'h3C};
        burst_words    = '{16'hBEEF, 16'h0123, 16'hCAFE, 16'h4567};

        add_frame(mcu_bridge_pkg::IDENTIFY, 8'h00, 2, 64'h0,
                  80'h64_64_64_64_00_00_00_00_00_00, 80'hFF_FF_FF_FF_00_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::REG_READ, mcu_bridge_pkg::STATUS, 4, 64'h0,
                  80'h00_01_00_00_00_00_00_00_00_00, 80'h00_FF_FF_FF_FF_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::MEM_ADDRESS, 4,
                  64'h78_56_34_12_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_READ, mcu_bridge_pkg::MEM_ADDRESS, 4, 64'h0,
                  80'h00_78_56_34_12_00_00_00_00_00, 80'h00_FF_FF_FF_FF_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::REG_READ, 8'd9, 4, 64'h0,
                  80'h0, 80'h00_FF_FF_FF_FF_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::MEM_WRITE, 8'h08, 8, 64'h11_22_33_44_55_66_77_88,
                  80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::MEM_READ, 8'h08, 8, 64'h0,
                  80'h00_11_22_33_44_55_66_77_88_00, 80'h00_FF_FF_FF_FF_FF_FF_FF_FF_00, 0);
        // Buffer to memory, 4 words at 0x100
        add_frame(mcu_bridge_pkg::MEM_WRITE, 8'h00, 8, 64'hBE_EF_01_23_CA_FE_45_67,
                  80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::MEM_ADDRESS, 4,
                  64'h00_01_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::MEM_SCR, 4,
                  64'h85_00_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_READ, mcu_bridge_pkg::MEM_SCR, 4, 64'h0,
                  80'h0, 80'h00_08_00_00_00_00_00_00_00_00, 1);
        // Memory to buffer, 3 words from 0x200
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::MEM_ADDRESS, 4,
                  64'h00_02_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::MEM_SCR, 4,
                  64'h61_00_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_READ, mcu_bridge_pkg::MEM_SCR, 4, 64'h0,
                  80'h0, 80'h00_08_00_00_00_00_00_00_00_00, 1);
        add_frame(mcu_bridge_pkg::MEM_READ, 8'h00, 8, 64'h0,
                  80'h00_A4_A5_A4_A4_A4_A7_45_67_00, 80'h00_FF_FF_FF_FF_FF_FF_FF_FF_00, 0);
        add_frame(mcu_bridge_pkg::USB_STATUS, 8'h00, 0, 64'h0,
                  80'h01_01_00_00_00_00_00_00_00_00, 80'hFF_FF_00_00_00_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::USB_READ, 8'h00, 0, 64'h0,
                  80'h3C_3C_00_00_00_00_00_00_00_00, 80'hFF_FF_00_00_00_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::USB_WRITE, 8'hC3, 0, 64'h0,
                  80'h0, 80'hFF_FF_00_00_00_00_00_00_00_00, 0);
        // USB_SCR flags, then three pulse writes with distinct bit sets
        add_frame(mcu_bridge_pkg::REG_READ, mcu_bridge_pkg::USB_SCR, 4, 64'h0,
                  80'h00_02_00_00_00_00_00_00_00_00, 80'h00_FF_FF_FF_FF_00_00_00_00_00, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::USB_SCR, 4,
                  64'h31_00_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::USB_SCR, 4,
                  64'h11_00_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        add_frame(mcu_bridge_pkg::REG_WRITE, mcu_bridge_pkg::USB_SCR, 4,
                  64'h01_00_00_00_00_00_00_00, 80'h0, 80'h0, 0);
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (10) @(posedge clk); // Board inputs settle through the syncs

        foreach (frames[i]) begin
            done = 1'b0;
            for (int t = 0; t < 8 && !done; t++) begin
                run_frame(frames[i], reply);
                done = !frames[i].poll || ((reply[1] & frames[i].mask[1]) == frames[i].exp[1]);
            end
            for (int k = 0; k < int'(frames[i].n) + 2; k++) begin
                if (frames[i].mask[k] != 8'h00) begin
                    check($sformatf("tx_data frame %0d byte %0d", i, k),
                          32'(reply[k] & frames[i].mask[k]),
                          32'(frames[i].exp[k] & frames[i].mask[k]));
                end
            end
        end

        repeat (5) @(posedge clk);
        for (int w = 0; w < 4; w++) begin
            check($sformatf("memory word %0d", w), 32'(mem_i.words[10'h080 + w]),
                  32'(burst_words[w]));
        end
        check("tx_write count", 32'(tx_writes), 32'd1);
        check("rx_read count", 32'(rx_reads), 32'd1);
        check("fifo_flush count", 32'(fifo_flushes), 32'd3);
        check("usb_reset_ack count", 32'(reset_acks), 32'd2);
        check("write_buffer_flush count", 32'(buffer_flushes), 32'd1);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
    input  logic                     clk,
    input  logic                     reset,
    input  mcu_bridge_pkg::mem_req_t mem_req,
    output mcu_bridge_pkg::mem_rsp_t mem_rsp
);

    logic [15:0] words [0:1023]; // Indexed by address divided by 2
    logic [1:0]  delay;
    logic        waiting;
    integer      seed;

    initial begin
        seed    = 50;
        mem_rsp = '0;
        waiting = 1'b0;
        delay   = 2'd0;
        for (int i = 0; i < 1024; i++) begin
            words[i] = 16'(i) ^ 16'hA5A5;
        end
    end

    // Ack after a random wait of 0 to 3 cycles
    always @(posedge clk) begin
        mem_rsp.ack <= 1'b0;
        if (reset) begin
            waiting <= 1'b0;
        end else if (mem_req.request && !mem_rsp.ack) begin
            if (!waiting) begin
                delay   <= 2'($random(seed));
                waiting <= 1'b1;
            end else if (delay == 2'd0) begin
                mem_rsp.ack   <= 1'b1;
                mem_rsp.rdata <= words[mem_req.address[10:1]];
                if (mem_req.write) words[mem_req.address[10:1]] <= mem_req.wdata;
                waiting <= 1'b0;
            end else begin
                delay <= delay - 2'd1;
            end
        end
    end

endmodule

// File: verilog/mcu_bridge_top.sv
`timescale 1ns/10ps

module mcu_bridge_top #(
    parameter logic [7:0] DEVICE_ID   = 8'h64,
    parameter int         SYNC_STAGES = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         frame_start,
    input  logic                         data_ready,
    input  logic [7:0]                   rx_data,
    input  logic                         sd_det,
    input  logic                         button,
    input  mcu_bridge_pkg::mem_rsp_t     mem_rsp,
    input  mcu_bridge_pkg::fifo_status_t fifo_status,
    output logic [7:0]                   tx_data,
    output mcu_bridge_pkg::mem_req_t     mem_req,
    output mcu_bridge_pkg::fifo_req_t    fifo_req,
    output logic                         usb_reset_ack,
    output logic                         write_buffer_flush
);

    mcu_bridge_pkg::reg_access_t reg_access;
    mcu_bridge_pkg::buf_access_t buf_access;
    mcu_bridge_pkg::mem_ctrl_t   mem_ctrl;

    logic [31:0] reg_rdata;
    logic [15:0] buf_rdata;
    logic        busy;
    logic        rx_read;
    logic        tx_write;
    logic [7:0]  tx_wdata;
    logic        fifo_flush;

    assign fifo_req = '{rx_read: rx_read, tx_write: tx_write, tx_wdata: tx_wdata,
                        fifo_flush: fifo_flush};

    mcu_cmd_decoder #(
        .DEVICE_ID(DEVICE_ID)
    ) decoder_i (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .reg_rdata(reg_rdata),
        .buf_rdata(buf_rdata),
        .fifo_status(fifo_status),
        .tx_data(tx_data),
        .reg_access(reg_access),
        .buf_access(buf_access),
        .rx_read(rx_read),
        .tx_write(tx_write),
        .tx_wdata(tx_wdata)
    );

    mcu_reg_file #(
        .SYNC_STAGES(SYNC_STAGES)
    ) reg_file_i (
        .clk(clk),
        .reset(reset),
        .sd_det(sd_det),
        .button(button),
        .reg_access(reg_access),
        .busy(busy),
        .fifo_status(fifo_status),
        .reg_rdata(reg_rdata),
        .mem_ctrl(mem_ctrl),
        .fifo_flush(fifo_flush),
        .usb_reset_ack(usb_reset_ack),
        .write_buffer_flush(write_buffer_flush)
    );

    mem_transfer transfer_i (
        .clk(clk),
        .reset(reset),
        .buf_access(buf_access),
        .mem_ctrl(mem_ctrl),
        .mem_rsp(mem_rsp),
        .buf_rdata(buf_rdata),
        .busy(busy),
        .mem_req(mem_req)
    );

endmodule

// File: verilog/mem_transfer.sv
`timescale 1ns/10ps

module mem_transfer (
    input  logic                        clk,
    input  logic                        reset,
    input  mcu_bridge_pkg::buf_access_t buf_access,
    input  mcu_bridge_pkg::mem_ctrl_t   mem_ctrl,
    input  mcu_bridge_pkg::mem_rsp_t    mem_rsp,
    output logic [15:0]                 buf_rdata,
    output logic                        busy,
    output mcu_bridge_pkg::mem_req_t    mem_req
);

    logic [15:0] buffer [0:mcu_bridge_pkg::BUFFER_WORDS-1];

    logic       stop_pending;
    logic [8:0] counter;
    logic       word_done;

    assign word_done = busy && mem_req.request && mem_rsp.ack;

    // ==============================
    // Word buffer
    // ==============================

    always_ff @(posedge clk) begin
        if (buf_access.read) begin
            buf_rdata <= buffer[buf_access.index];
        end
        if (buf_access.write) begin
            buffer[buf_access.index] <= buf_access.wdata;
        end
        if (word_done && !mem_req.write) begin
            buffer[counter] <= mem_rsp.rdata; // Memory to buffer
        end
    end

    // ==============================
    // Burst engine
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            busy            <= 1'b0;
            stop_pending    <= 1'b0;
            mem_req.request <= 1'b0;
        end else begin
            if (mem_ctrl.stop) begin
                stop_pending <= busy;
            end else if (mem_ctrl.start && !busy) begin
                mem_req.write   <= mem_ctrl.direction;
                mem_req.address <= mem_ctrl.address;
                counter         <= 9'd0;
                busy            <= 1'b1;
            end

            if (busy) begin
                if (!mem_req.request) begin
                    mem_req.request <= 1'b1;
                    mem_req.wdata   <= buffer[counter];
                end

                if (mem_req.request && mem_rsp.ack) begin
                    mem_req.request <= 1'b0;
                    mem_req.address <= mem_req.address + 32'd2;
                    counter         <= counter + 9'd1;
                    if ((counter == mem_ctrl.last_index) || stop_pending) begin
                        busy         <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

    // Bus holds the request steady until the memory answers
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        (mem_req.request && !mem_rsp.ack) |=> (mem_req.request && $stable(mem_req.address)));

endmodule

// File: verilog/mcu_reg_file.sv
`timescale 1ns/10ps

module mcu_reg_file #(
    parameter int SYNC_STAGES = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sd_det,
    input  logic                         button,
    input  mcu_bridge_pkg::reg_access_t  reg_access,
    input  logic                         busy,
    input  mcu_bridge_pkg::fifo_status_t fifo_status,
    output logic [31:0]                  reg_rdata,
    output mcu_bridge_pkg::mem_ctrl_t    mem_ctrl,
    output logic                         fifo_flush,
    output logic                         usb_reset_ack,
    output logic                         write_buffer_flush
);

    logic [SYNC_STAGES-1:0] sd_det_ff;
    logic [SYNC_STAGES-1:0] button_ff;

    mcu_bridge_pkg::reg_word_u write_word;
    mcu_bridge_pkg::reg_word_u read_word;

    logic        mem_start;
    logic        mem_stop;
    logic        mem_direction;
    logic [8:0]  last_index;
    logic [31:0] mem_address;
    logic [9:0]  length_m1;

    // Board inputs
    always_ff @(posedge clk) begin
        sd_det_ff <= {sd_det_ff[SYNC_STAGES-2:0], sd_det};
        button_ff <= {button_ff[SYNC_STAGES-2:0], button};
    end

    assign write_word = reg_access.wdata;
    assign length_m1  = write_word.mem_scr.length - 10'd1;

    assign mem_ctrl = '{start: mem_start, stop: mem_stop, direction: mem_direction,
                        last_index: last_index, address: mem_address};

    // ==============================
    // Register write
    // ==============================

    always_ff @(posedge clk) begin
        mem_start          <= 1'b0;
        mem_stop           <= 1'b0;
        fifo_flush         <= 1'b0;
        usb_reset_ack      <= 1'b0;
        write_buffer_flush <= 1'b0;

        if (reset) begin
            mem_direction <= 1'b0;
            last_index    <= 9'd0;
            mem_address   <= 32'd0;
        end else if (reg_access.write) begin
            case (reg_access.address)
                mcu_bridge_pkg::MEM_ADDRESS: mem_address <= reg_access.wdata;
                mcu_bridge_pkg::MEM_SCR: begin
                    mem_start     <= write_word.mem_scr.start;
                    mem_stop      <= write_word.mem_scr.stop;
                    mem_direction <= write_word.mem_scr.direction;
                    last_index    <= length_m1[8:0]; // Length minus one
                end
                mcu_bridge_pkg::USB_SCR: begin
                    fifo_flush         <= write_word.usb_scr.fifo_flush;
                    usb_reset_ack      <= write_word.usb_scr.reset_ack;
                    write_buffer_flush <= write_word.usb_scr.write_buffer_flush;
                end
                default: ; // STATUS and unmapped ignore writes
            endcase
        end
    end

    // ==============================
    // Register read
    // ==============================

    always_comb begin
        read_word = '0;
        case (reg_access.address)
            mcu_bridge_pkg::STATUS: begin
                read_word = {30'd0, ~sd_det_ff[SYNC_STAGES-1], ~button_ff[SYNC_STAGES-1]};
            end
            mcu_bridge_pkg::MEM_ADDRESS: read_word = mem_address;
            mcu_bridge_pkg::MEM_SCR:     read_word.mem_scr.busy = busy;
            mcu_bridge_pkg::USB_SCR: begin
                read_word.usb_scr.tx_not_full  = ~fifo_status.tx_full;
                read_word.usb_scr.rx_not_empty = ~fifo_status.rx_empty;
            end
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_access.read) reg_rdata <= read_word;
    end

endmodule

// File: verilog/mcu_cmd_decoder.sv
`timescale 1ns/10ps

module mcu_cmd_decoder #(
    parameter logic [7:0] DEVICE_ID = 8'h64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         frame_start,
    input  logic                         data_ready,
    input  logic [7:0]                   rx_data,
    input  logic [31:0]                  reg_rdata,
    input  logic [15:0]                  buf_rdata,
    input  mcu_bridge_pkg::fifo_status_t fifo_status,
    output logic [7:0]                   tx_data,
    output mcu_bridge_pkg::reg_access_t  reg_access,
    output mcu_bridge_pkg::buf_access_t  buf_access,
    output logic                         rx_read,
    output logic                         tx_write,
    output logic [7:0]                   tx_wdata
);

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    phase_e               phase;
    mcu_bridge_pkg::cmd_e cmd;
    logic [1:0]           counter;
    logic [7:0]           address;
    logic                 word_select;

    logic        reg_read;
    logic        reg_write;
    logic [31:0] reg_wdata;
    logic        buf_read;
    logic        buf_write;
    logic [15:0] buf_wdata;
    logic [7:0]  usb_rdata;

    assign reg_access = '{read: reg_read, write: reg_write, address: address, wdata: reg_wdata};
    assign buf_access = '{read: buf_read, write: buf_write, index: {address, word_select},
                          wdata: buf_wdata};

    // ==============================
    // Phase machine
    // ==============================

    always_ff @(posedge clk) begin
        reg_read  <= 1'b0;
        reg_write <= 1'b0;
        buf_read  <= 1'b0;
        buf_write <= 1'b0;
        rx_read   <= 1'b0;
        tx_write  <= 1'b0;

        if (reset) begin
            phase       <= PHASE_NOP;
            cmd         <= mcu_bridge_pkg::IDENTIFY;
            counter     <= 2'd0;
            address     <= 8'd0;
            word_select <= 1'b0;
        end else begin
            if (frame_start) begin
                counter <= 2'd0;
                phase   <= PHASE_CMD;
            end

            // Address steps after each register access and each odd buffer word
            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd   <= mcu_bridge_pkg::cmd_e'(rx_data);
                        phase <= PHASE_ADDRESS;
                        case (rx_data)
                            mcu_bridge_pkg::USB_STATUS: phase <= PHASE_NOP;
                            mcu_bridge_pkg::USB_READ: begin
                                rx_read   <= 1'b1;
                                usb_rdata <= fifo_status.rx_rdata; // Byte shown before the pop
                                phase     <= PHASE_DATA;
                            end
                            mcu_bridge_pkg::USB_WRITE: phase <= PHASE_DATA;
                            default: ;
                        endcase
                    end

                    PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase   <= PHASE_DATA;
                        if (cmd == mcu_bridge_pkg::REG_READ) reg_read <= 1'b1;
                        if (cmd == mcu_bridge_pkg::MEM_READ) begin
                            buf_read    <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        case (cmd)
                            mcu_bridge_pkg::REG_READ: reg_read <= (counter == 2'd3);
                            mcu_bridge_pkg::REG_WRITE: begin
                                reg_wdata[8*counter +: 8] <= rx_data; // Little endian
                                reg_write <= (counter == 2'd3);
                            end
                            mcu_bridge_pkg::MEM_READ: begin
                                if (counter[0]) begin
                                    buf_read    <= 1'b1;
                                    word_select <= ~word_select;
                                end
                            end
                            mcu_bridge_pkg::MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_write      <= 1'b1;
                                    word_select    <= counter[1];
                                end else begin
                                    buf_wdata[15:8] <= rx_data; // High byte first
                                end
                            end
                            mcu_bridge_pkg::USB_READ: phase <= PHASE_NOP;
                            mcu_bridge_pkg::USB_WRITE: begin
                                tx_write <= 1'b1;
                                tx_wdata <= rx_data;
                                phase    <= PHASE_NOP;
                            end
                            default: ;
                        endcase
                    end

                    default: ; // NOP waits for the next frame
                endcase
            end
        end
    end

    // ==============================
    // Reply byte
    // ==============================

    always_comb begin
        tx_data = 8'h00;
        case (cmd)
            mcu_bridge_pkg::IDENTIFY: tx_data = DEVICE_ID;
            mcu_bridge_pkg::REG_READ: tx_data = reg_rdata[8*counter +: 8];
            mcu_bridge_pkg::MEM_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            mcu_bridge_pkg::USB_STATUS: begin
                tx_data = {6'd0, ~fifo_status.tx_full, ~fifo_status.rx_empty};
            end
            mcu_bridge_pkg::USB_READ: tx_data = usb_rdata;
            default: tx_data = 8'h00;
        endcase
    end

    // The register file serves one access per cycle
    a_reg_one_access: assert property (@(posedge clk) disable iff (reset)
        !(reg_access.read && reg_access.write));

endmodule

// File: verilog/mcu_bridge_pkg.sv
package mcu_bridge_pkg;

    // ==============================
    // Protocol encodings
    // ==============================

    localparam int BUFFER_WORDS = 512; // 8-bit address plus word select

    typedef enum logic [7:0] {
        IDENTIFY   = 8'd0,
        REG_READ   = 8'd1,
        REG_WRITE  = 8'd2,
        MEM_READ   = 8'd3,
        MEM_WRITE  = 8'd4,
        USB_STATUS = 8'd5,
        USB_READ   = 8'd6,
        USB_WRITE  = 8'd7
    } cmd_e;

    typedef enum logic [7:0] {
        STATUS      = 8'd0,
        MEM_ADDRESS = 8'd1,
        MEM_SCR     = 8'd2,
        USB_SCR     = 8'd3
    } reg_addr_e;

    // ==============================
    // Register word layouts
    // ==============================

    typedef struct packed {
        logic [16:0] reserved_hi;
        logic [9:0]  length;      // In words
        logic        reserved_lo;
        logic        busy;
        logic        direction;   // 1 = buffer to memory
        logic        stop;
        logic        start;
    } mem_scr_t;

    typedef struct packed {
        logic [25:0] reserved_hi;
        logic        write_buffer_flush;
        logic        reset_ack;
        logic        reserved_lo;
        logic        tx_not_full;
        logic        rx_not_empty;
        logic        fifo_flush;
    } usb_scr_t;

    typedef union packed {
        mem_scr_t mem_scr;
        usb_scr_t usb_scr;
    } reg_word_u;

    // ==============================
    // Internal and external buses
    // ==============================

    typedef struct packed {
        logic        read;
        logic        write;
        logic [7:0]  address;
        logic [31:0] wdata;
    } reg_access_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [8:0]  index;
        logic [15:0] wdata;
    } buf_access_t;

    typedef struct packed {
        logic        start;
        logic        stop;
        logic        direction;
        logic [8:0]  last_index;
        logic [31:0] address;
    } mem_ctrl_t;

    typedef struct packed {
        logic        request;
        logic        write;
        logic [31:0] address;
        logic [15:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       rx_read;
        logic       tx_write;
        logic [7:0] tx_wdata;
        logic       fifo_flush;
    } fifo_req_t;

    typedef struct packed {
        logic       rx_empty;
        logic       tx_full;
        logic [7:0] rx_rdata;
    } fifo_status_t;

endpackage
